/* sources.f */
+incdir+bench
hdl/nes_pad_pkg.sv
hdl/nes_port_pkg.sv
hdl/pad_turbo.sv
hdl/joypad_port.sv
hdl/nes_input_top.sv
bench/tb_nes_input.sv

/* run.sh */
#!/bin/sh
# build and run the controller input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_nes_input \
  -f sources.f \
  -o sim_nes_input

./obj_dir/sim_nes_input > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
fi
exit 1

/* bench/pad_model.svh */
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

// 16 bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_state;

// reference turbo state, one entry per player
logic model_phase [4];
int   model_count [4];

// steps the lfsr once per bit, newest bit ends up in bit 0
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    val        = {val[30:0], fb};
  end
  return val;
endfunction

task automatic model_clear();
  for (int p = 0; p < 4; p++) begin
    model_phase[p] = 1'b0;
    model_count[p] = 0;
  end
endtask

// one vsync rise seen by every player
task automatic model_vsync(input int speed);
  for (int p = 0; p < 4; p++) begin
    if (speed != 0) begin
      model_count[p] = model_count[p] + 1;
      if (model_count[p] >= speed) begin
        model_count[p] = 0;
        model_phase[p] = ~model_phase[p];
      end
    end
  end
endtask

// buttons as the console should see them
function automatic nes_pad_pkg::pad_buttons_t expected_report(
  input nes_pad_pkg::pad_input_t pad,
  input logic                    phase
);
  nes_pad_pkg::pad_buttons_t r;
  r = pad.buttons;
  if (phase && pad.a_turbo) begin
    r.a = 1'b1;
  end
  if (phase && pad.b_turbo) begin
    r.b = 1'b1;
  end
  return r;
endfunction

// 24 bit word for one port, first pad in the low byte
function automatic nes_port_pkg::port_word_t expected_word(
  input int                        port,
  input logic                      multitap,
  input logic                      swap,
  input nes_pad_pkg::pad_buttons_t p1,
  input nes_pad_pkg::pad_buttons_t p2,
  input nes_pad_pkg::pad_buttons_t p3,
  input nes_pad_pkg::pad_buttons_t p4
);
  nes_pad_pkg::pad_buttons_t first;
  nes_pad_pkg::pad_buttons_t tap;
  logic [7:0]                sig;
  if (port == 1) begin
    first = swap ? p2 : p1;
    tap   = p3;
    sig   = nes_port_pkg::SIG_PORT1;
  end else begin
    first = swap ? p1 : p2;
    tap   = p4;
    sig   = nes_port_pkg::SIG_PORT2;
  end
  if (!multitap) begin
    return {16'hffff, first};
  end
  return {sig, tap, first};
endfunction

`endif

/* bench/tb_nes_input.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_input;

  localparam int SPEED_BITS = nes_pad_pkg::TURBO_SPEED_BITS;
  // 6 tests x 40 reads x 70 cycles, rounded up
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int READS = 40;

  logic                     clk_ppu_21_47;
  logic                     reset_nes;
  nes_pad_pkg::pad_input_t  pads [4];
  logic                     vsync;
  logic [SPEED_BITS-1:0]    turbo_speed;
  logic                     multitap_enabled;
  logic                     swap_controllers;
  nes_port_pkg::port_ctrl_t port_ctrl;
  wire  [1:0]               port_data;

  int checks;
  int errors;
  int cycle_count;
  int test_start;

  `include "pad_model.svh"

  nes_input_top #(
    .SPEED_BITS(SPEED_BITS)
  ) dut_i (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .pads            (pads),
    .vsync           (vsync),
    .turbo_speed     (turbo_speed),
    .multitap_enabled(multitap_enabled),
    .swap_controllers(swap_controllers),
    .port_ctrl       (port_ctrl),
    .port_data       (port_data)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever begin
      #10 clk_ppu_21_47 = ~clk_ppu_21_47;
    end
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_ppu_21_47);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // inputs change just after the rising edge
  task automatic step_cycle();
    @(posedge clk_ppu_21_47);
    #2;
  endtask

  task automatic compare_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic randomize_pads();
    logic [31:0] bits;
    for (int p = 0; p < 4; p++) begin
      bits    = rand_bits(10);
      pads[p] = bits[9:0];
    end
  endtask

  task automatic pulse_vsync();
    vsync = 1'b1;
    step_cycle();
    vsync = 1'b0;
    step_cycle();
    model_vsync(int'(turbo_speed));
  endtask

  // strobe, then 24 bits plus two trailing bits on both ports
  task automatic read_ports(
    output nes_port_pkg::port_word_t word_p1,
    output nes_port_pkg::port_word_t word_p2,
    output logic [1:0]               tail_p1,
    output logic [1:0]               tail_p2
  );
    port_ctrl.strobe = 1'b1;
    step_cycle();
    port_ctrl.strobe = 1'b0;
    for (int i = 0; i < 26; i++) begin
      if (i < 24) begin
        word_p1[i] = port_data[0];
        word_p2[i] = port_data[1];
      end else begin
        tail_p1[i-24] = port_data[0];
        tail_p2[i-24] = port_data[1];
      end
      port_ctrl.clock_p1 = 1'b1;
      port_ctrl.clock_p2 = 1'b1;
      step_cycle();
      port_ctrl.clock_p1 = 1'b0;
      port_ctrl.clock_p2 = 1'b0;
      step_cycle();
    end
  endtask

  task automatic run_reads(input string name, input int count, input logic pulses);
    nes_port_pkg::port_word_t  exp_p1;
    nes_port_pkg::port_word_t  exp_p2;
    nes_port_pkg::port_word_t  got_p1;
    nes_port_pkg::port_word_t  got_p2;
    logic [1:0]                tail_p1;
    logic [1:0]                tail_p2;
    nes_pad_pkg::pad_buttons_t rep [4];
    logic [31:0]               bits;
    for (int r = 0; r < count; r++) begin
      randomize_pads();
      if (pulses) begin
        bits = rand_bits(2);
        repeat (int'(bits[1:0])) begin
          pulse_vsync();
        end
      end
      read_ports(got_p1, got_p2, tail_p1, tail_p2);
      for (int p = 0; p < 4; p++) begin
        rep[p] = expected_report(pads[p], model_phase[p]);
      end
      exp_p1 = expected_word(1, multitap_enabled, swap_controllers,
                             rep[0], rep[1], rep[2], rep[3]);
      exp_p2 = expected_word(2, multitap_enabled, swap_controllers,
                             rep[0], rep[1], rep[2], rep[3]);
      compare_value({name, " port1"}, {8'h00, exp_p1}, {8'h00, got_p1});
      compare_value({name, " port2"}, {8'h00, exp_p2}, {8'h00, got_p2});
      compare_value({name, " tail"}, 32'd0, {28'd0, tail_p2, tail_p1});
    end
  endtask

  initial begin
    logic [31:0] bits;
    reset_nes        = 1'b1;
    vsync            = 1'b0;
    turbo_speed      = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    port_ctrl        = '0;
    for (int p = 0; p < 4; p++) begin
      pads[p] = '0;
    end
    checks     = 0;
    errors     = 0;
    test_start = 0;
    lfsr_state = 16'd40;
    model_clear();

    repeat (5) begin
      step_cycle();
    end
    reset_nes = 1'b0;
    step_cycle();

    compare_value("reset", 32'd0, {30'd0, port_data});
    report_test("reset");

    run_reads("plain", READS, 1'b0);
    report_test("plain");

    multitap_enabled = 1'b1;
    run_reads("multitap", READS, 1'b0);
    report_test("multitap");

    // players 3 and 4 must stay put
    swap_controllers = 1'b1;
    run_reads("swap", READS, 1'b0);
    report_test("swap");

    swap_controllers = 1'b0;
    bits = rand_bits(3);
    turbo_speed = (bits[2:0] == 3'd0) ? 3'd1 : bits[2:0];
    run_reads("turbo", 2 * READS, 1'b1);
    report_test("turbo");

    // leave the phase set so that clearing it shows on the ports
    while (!model_phase[0]) begin
      pulse_vsync();
    end

    // dut clears the phase on the next edge
    turbo_speed = '0;
    step_cycle();
    model_clear();
    run_reads("turbo_off", READS, 1'b1);
    report_test("turbo_off");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/nes_input_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nes_input_top #(
  parameter int SPEED_BITS = nes_pad_pkg::TURBO_SPEED_BITS
) (
  input  wire                          clk_ppu_21_47,
  input  wire                          reset_nes,
  // players 1 to 4
  input  wire nes_pad_pkg::pad_input_t   pads [4],
  input  wire                          vsync,
  input  wire [SPEED_BITS-1:0]         turbo_speed,
  input  wire                          multitap_enabled,
  input  wire                          swap_controllers,
  input  wire nes_port_pkg::port_ctrl_t  port_ctrl,
  // bit 0 port 1, bit 1 port 2
  output wire [1:0]                    port_data
);

  // per player report bytes after turbo
  nes_pad_pkg::pad_buttons_t reports [4];

  // one turbo block per player, all sharing vsync and speed
  for (genvar p = 0; p < 4; p++) begin : g_player
    pad_turbo #(
      .SPEED_BITS(SPEED_BITS)
    ) turbo_i (
      .clk_ppu_21_47(clk_ppu_21_47),
      .reset_nes    (reset_nes),
      .pad          (pads[p]),
      .vsync        (vsync),
      .turbo_speed  (turbo_speed),
      .report       (reports[p])
    );
  end

  // both serial ports
  joypad_port port_i (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .reports         (reports),
    .multitap_enabled(multitap_enabled),
    .swap_controllers(swap_controllers),
    .port_ctrl       (port_ctrl),
    .port_data       (port_data)
  );

endmodule

`default_nettype wire

/* hdl/joypad_port.sv */
`timescale 1ns/1ps
`default_nettype none

module joypad_port (
  input  wire                          clk_ppu_21_47,
  input  wire                          reset_nes,
  input  wire nes_pad_pkg::pad_buttons_t reports [4],
  input  wire                          multitap_enabled,
  input  wire                          swap_controllers,
  input  wire nes_port_pkg::port_ctrl_t  port_ctrl,
  output logic [1:0]                   port_data
);

  // serial shift registers, bit 0 is on the data line
  nes_port_pkg::port_word_t shift_p1;
  nes_port_pkg::port_word_t shift_p2;

  // words latched on strobe
  nes_port_pkg::port_word_t load_p1;
  nes_port_pkg::port_word_t load_p2;

  // pad byte that goes out first on each port
  nes_pad_pkg::pad_buttons_t first_p1;
  nes_pad_pkg::pad_buttons_t first_p2;

  // previous port clocks, bit 0 is port 1
  logic [1:0] clk_hist;
  logic       fall_p1;
  logic       fall_p2;

  // upper 16 bits are the multitap pad and the signature,
  // or all ones when no multitap is attached
  function automatic nes_port_pkg::port_word_t build_word(
    input logic                      multitap,
    input logic [7:0]                sig,
    input nes_pad_pkg::pad_buttons_t upper,
    input nes_pad_pkg::pad_buttons_t first
  );
    logic [15:0] high;
    high = multitap ? {sig, upper} : 16'hffff;
    return {high, first};
  endfunction

  // swap trades players 1 and 2 only
  assign first_p1 = swap_controllers ? reports[1] : reports[0];
  assign first_p2 = swap_controllers ? reports[0] : reports[1];

  assign load_p1 = build_word(multitap_enabled, nes_port_pkg::SIG_PORT1,
                              reports[2], first_p1);
  assign load_p2 = build_word(multitap_enabled, nes_port_pkg::SIG_PORT2,
                              reports[3], first_p2);

  assign fall_p1 = ~port_ctrl.clock_p1 & clk_hist[0];
  assign fall_p2 = ~port_ctrl.clock_p2 & clk_hist[1];

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      clk_hist <= 2'b00;
    end else begin
      clk_hist <= {port_ctrl.clock_p2, port_ctrl.clock_p1};
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_p1 <= '0;
      shift_p2 <= '0;
    end else begin
      if (port_ctrl.strobe) begin
        shift_p1 <= load_p1;
        shift_p2 <= load_p2;
      end
      // a shift in the same cycle wins over the load
      if (fall_p1) begin
        shift_p1 <= {1'b0, shift_p1[nes_port_pkg::REPORT_BITS-1:1]};
      end
      if (fall_p2) begin
        shift_p2 <= {1'b0, shift_p2[nes_port_pkg::REPORT_BITS-1:1]};
      end
    end
  end

  // data lines come straight from the register outputs
  assign port_data = {shift_p2[0], shift_p1[0]};

endmodule

`default_nettype wire

/* hdl/pad_turbo.sv */
`timescale 1ns/1ps
`default_nettype none

module pad_turbo #(
  parameter int SPEED_BITS = 3
) (
  input  wire                        clk_ppu_21_47,
  input  wire                        reset_nes,
  input  wire nes_pad_pkg::pad_input_t pad,
  input  wire                        vsync,
  input  wire [SPEED_BITS-1:0]       turbo_speed,
  output nes_pad_pkg::pad_buttons_t  report
);

  // vsync history for edge detect
  logic vsync_prev;
  logic vsync_rise;

  // frames counted since the last phase toggle
  logic [SPEED_BITS-1:0] frame_cnt;
  // one bit wider so a lowered speed cannot wrap the compare
  logic [SPEED_BITS:0]   cnt_next;

  // turbo phase, high means turbo buttons read as pressed
  logic phase;

  assign vsync_rise = vsync & ~vsync_prev;
  assign cnt_next   = {1'b0, frame_cnt} + 1'b1;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      vsync_prev <= 1'b0;
    end else begin
      vsync_prev <= vsync;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame_cnt <= '0;
      phase     <= 1'b0;
    end else if (turbo_speed == '0) begin
      // turbo off, hold everything at zero
      frame_cnt <= '0;
      phase     <= 1'b0;
    end else if (vsync_rise) begin
      if (cnt_next >= {1'b0, turbo_speed}) begin
        frame_cnt <= '0;
        phase     <= ~phase;
      end else begin
        frame_cnt <= cnt_next[SPEED_BITS-1:0];
      end
    end
  end

  // report follows the live buttons with no delay
  // only a and b pick up the turbo phase
  always_comb begin
    report   = pad.buttons;
    report.a = pad.buttons.a | (pad.a_turbo & phase);
    report.b = pad.buttons.b | (pad.b_turbo & phase);
  end

endmodule

`default_nettype wire

/* hdl/nes_port_pkg.sv */
`default_nettype none

package nes_port_pkg;

  // bits in one port word
  // first pad byte, then multitap pad byte, then signature byte
  localparam int REPORT_BITS = 24;

  // multitap signature bytes, one per port
  localparam logic [7:0] SIG_PORT1 = 8'h08;
  localparam logic [7:0] SIG_PORT2 = 8'h04;

  // control lines from the core
  // strobe latches both ports, each clock shifts its own port
  typedef struct packed {
    logic strobe;
    logic clock_p1;
    logic clock_p2;
  } port_ctrl_t;

  // shift contents of one serial port
  typedef logic [REPORT_BITS-1:0] port_word_t;

endpackage

`default_nettype wire

/* hdl/nes_pad_pkg.sv */
`default_nettype none

package nes_pad_pkg;

  // console report byte
  // shifted out lsb first, so a is read first and right is read last
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_t;

  // one game pad as it arrives from the host side
  // the turbo bits are separate hold buttons, not part of the report
  typedef struct packed {
    pad_buttons_t buttons;
    logic         a_turbo;
    logic         b_turbo;
  } pad_input_t;

  // default width of the turbo speed setting
  // a setting of n toggles the turbo phase every n frames, 0 turns turbo off
  localparam int TURBO_SPEED_BITS = 3;

endpackage

`default_nettype wire
